/* common/ahbPkg.sv */
/*
 * AHB-Lite protocol definitions
 * Address and data types, transfer type and the request and response bundles
 */
package ahbPkg;

  // Bus widths, one word each
  typedef logic [31:0] addrT;
  typedef logic [31:0] dataT;

  // HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransT;

  // HRESP values
  localparam logic RespOkay  = 1'b0;
  localparam logic RespError = 1'b1;

  // Address phase from master plus the write data of its data phase
  typedef struct packed {
    logic         sel;
    addrT         addr;
    logic         write;
    logic [2:0]   size;
    htransT       trans;
    logic         mastLock;
    dataT         wdata;
  } ahbReqT;

  // Slave response back to the master
  typedef struct packed {
    dataT         rdata;
    logic         readyOut;
    logic         resp;
  } ahbRespT;

endpackage

/* common/matrixPkg.sv */
/*
 * Bus matrix definitions
 * Master priority and the slave port arbiter states
 */
package matrixPkg;

  // Master priority, the higher value wins
  typedef logic [2:0] priorityT;

  // Slave port arbiter
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ADDR,
    ARB_DATA,
    ARB_LOCKED
  } arbStateT;

endpackage

/* busMatrix/masterPort.sv */
/*
 * Bus matrix master port
 * Decodes addresses, holds ungranted requests and routes the owning slave response
 */
`timescale 1ns/1ns

module masterPort #(
  parameter int Slaves = 2,
  parameter ahbPkg::addrT [Slaves-1:0] SlaveBase = '0,
  parameter ahbPkg::addrT [Slaves-1:0] SlaveMask = '0
) (
  input  logic                         HCLK,
  input  logic                         reset,
  input  ahbPkg::ahbReqT               mstReq,
  input  matrixPkg::priorityT          mstPriority,
  output ahbPkg::ahbRespT              mstResp,
  input  ahbPkg::ahbRespT [Slaves-1:0] slvResp,
  input  logic [Slaves-1:0]            granted,
  output ahbPkg::ahbReqT               slvReq,
  output logic [Slaves-1:0]            slvSel,
  output matrixPkg::priorityT          slvPriority,
  output logic                         canSwitch
);

  logic              pendValid;
  ahbPkg::ahbReqT    pendReq;
  ahbPkg::ahbReqT    curReq;
  logic              liveValid;
  logic              acceptLive;
  logic              curValid;
  logic [Slaves-1:0] hit;
  logic              mapped;
  logic [Slaves-1:0] readyVec;
  logic              goIssue;
  logic              dataValid;
  logic [Slaves-1:0] dataSel;
  logic              dataReady;
  ahbPkg::ahbRespT   dataResp;
  logic              errFirst;
  logic              errSecond;
  logic              lockHeld;

  ////////////////////////////////////////
  // Decode and issue
  ////////////////////////////////////////

  // A live transfer counts only when the master sees its own ready high
  assign liveValid  = mstReq.sel && mstReq.trans[1];
  assign acceptLive = !pendValid && liveValid && mstResp.readyOut;
  assign curValid   = pendValid || acceptLive;
  // Pending copy replays ahead of anything on the live bus
  assign curReq     = pendValid ? pendReq : mstReq;

  always_comb begin
    for (int s = 0; s < Slaves; s++) begin
      hit[s]      = curReq.sel && ((curReq.addr & SlaveMask[s]) == SlaveBase[s]);
      readyVec[s] = slvResp[s].readyOut;
    end
  end

  assign mapped  = |hit;
  // Goes out only into a granted and idle slave
  assign goIssue = curValid && |(hit & granted & readyVec);

  always_comb begin
    slvReq       = curReq;
    slvReq.sel   = curValid;
    slvReq.trans = goIssue ? curReq.trans : ahbPkg::IDLE;
    // Write data always comes from the master, it holds it during the wait
    slvReq.wdata = mstReq.wdata;
  end

  // Select doubles as the arbitration request
  assign slvSel      = hit & {Slaves{curValid}};
  assign slvPriority = mstPriority;
  assign canSwitch   = !dataValid && !goIssue && !lockHeld;

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////

  always_comb begin
    dataResp = '0;
    for (int s = 0; s < Slaves; s++) begin
      if (dataSel[s]) begin
        dataResp = slvResp[s];
      end
    end
  end

  assign dataReady = |(dataSel & readyVec);

  // Default slave first, then the held request, then the owning slave
  always_comb begin
    mstResp          = '0;
    mstResp.readyOut = 1'b1;
    mstResp.resp     = ahbPkg::RespOkay;
    if (errFirst) begin
      mstResp.readyOut = 1'b0;
      mstResp.resp     = ahbPkg::RespError;
    end else if (errSecond) begin
      mstResp.resp = ahbPkg::RespError;
    end else if (pendValid) begin
      mstResp.readyOut = 1'b0;
    end else if (dataValid) begin
      mstResp = dataResp;
    end
  end

  always_ff @(posedge HCLK) begin
    if (reset) begin
      pendValid <= 1'b0;
      dataValid <= 1'b0;
      dataSel   <= '0;
      errFirst  <= 1'b0;
      errSecond <= 1'b0;
      lockHeld  <= 1'b0;
    end else begin
      // Hold an accepted transfer whose slave is not ours yet
      if (pendValid) begin
        pendValid <= !goIssue;
      end else begin
        pendValid <= acceptLive && mapped && !goIssue;
      end
      if (goIssue) begin
        dataValid <= 1'b1;
        dataSel   <= hit;
      end else if (dataValid && dataReady) begin
        dataValid <= 1'b0;
      end
      // Two cycle ERROR for an unmapped address
      errFirst  <= acceptLive && !mapped;
      errSecond <= errFirst;
      // Lock lasts until the master drops HMASTLOCK
      lockHeld  <= goIssue ? curReq.mastLock : (lockHeld && mstReq.mastLock);
    end
  end

  always_ff @(posedge HCLK) begin
    if (!pendValid && acceptLive) begin
      pendReq <= mstReq;
    end
  end

endmodule

/* busMatrix/slavePort.sv */
/*
 * Bus matrix slave port
 * Priority arbiter with grant holding, request mux and data phase owner tracking
 */
`timescale 1ns/1ns

module slavePort #(
  parameter int Masters = 2
) (
  input  logic                                 HCLK,
  input  logic                                 reset,
  input  ahbPkg::ahbReqT      [Masters-1:0]    mstReq,
  input  matrixPkg::priorityT [Masters-1:0]    mstPriority,
  input  logic                [Masters-1:0]    mstSel,
  input  logic                [Masters-1:0]    canSwitch,
  output ahbPkg::ahbRespT                      mstResp,
  output logic                [Masters-1:0]    grant,
  output ahbPkg::ahbReqT                       slvReq,
  input  ahbPkg::ahbRespT                      slvResp
);

  matrixPkg::arbStateT state;
  logic [Masters-1:0]  pick;
  matrixPkg::priorityT bestPri;
  logic                found;
  logic                ownerHold;
  logic [Masters-1:0]  dataOwner;
  logic                slvAccept;

  ////////////////////////////////////////
  // Priority pick
  ////////////////////////////////////////

  // Strict compare lets the lower index keep a tie
  always_comb begin
    pick    = '0;
    bestPri = '0;
    found   = 1'b0;
    for (int m = 0; m < Masters; m++) begin
      if (mstSel[m] && (!found || mstPriority[m] > bestPri)) begin
        found   = 1'b1;
        bestPri = mstPriority[m];
        pick    = '0;
        pick[m] = 1'b1;
      end
    end
  end

  // Owner busy or locked
  assign ownerHold = |(grant & ~canSwitch);

  ////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////

  always_comb begin
    slvReq = '0;
    for (int m = 0; m < Masters; m++) begin
      if (grant[m]) begin
        slvReq     = mstReq[m];
        slvReq.sel = mstSel[m];
      end
    end
    // Write data follows the data phase owner, one phase behind
    slvReq.wdata = '0;
    for (int m = 0; m < Masters; m++) begin
      if (dataOwner[m] && state == matrixPkg::ARB_DATA) begin
        slvReq.wdata = mstReq[m].wdata;
      end
    end
  end

  assign slvAccept = slvReq.sel && slvReq.trans[1] && slvResp.readyOut;

  // Each master port keeps the broadcast response only in its own data phase
  assign mstResp = slvResp;

  ////////////////////////////////////////
  // Arbiter FSM
  ////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (reset) begin
      state     <= matrixPkg::ARB_IDLE;
      grant     <= '0;
      dataOwner <= '0;
    end else begin
      if (slvAccept) begin
        state     <= matrixPkg::ARB_DATA;
        dataOwner <= grant;
      end else if (state == matrixPkg::ARB_DATA && !slvResp.readyOut) begin
        state <= matrixPkg::ARB_DATA;
      end else if (ownerHold) begin
        // Owner cannot let go yet
        state <= matrixPkg::ARB_LOCKED;
      end else if (found) begin
        grant <= pick;
        state <= matrixPkg::ARB_ADDR;
      end else begin
        // Nobody asking so the slave is released
        grant <= '0;
        state <= matrixPkg::ARB_IDLE;
      end
    end
  end

endmodule

/* busMatrix/busMatrix.sv */
/*
 * AHB-Lite bus matrix
 * Cross wiring of master ports to slave ports
 */
`timescale 1ns/1ns

module busMatrix #(
  parameter int Masters = 2,
  parameter int Slaves  = 2,
  parameter ahbPkg::addrT [Slaves-1:0] SlaveBase = '0,
  parameter ahbPkg::addrT [Slaves-1:0] SlaveMask = '0
) (
  input  logic                               HCLK,
  input  logic                               reset,
  input  ahbPkg::ahbReqT      [Masters-1:0]  masterReq,
  input  matrixPkg::priorityT [Masters-1:0]  masterPriority,
  output ahbPkg::ahbRespT     [Masters-1:0]  masterResp,
  output ahbPkg::ahbReqT      [Slaves-1:0]   slaveReq,
  input  ahbPkg::ahbRespT     [Slaves-1:0]   slaveResp
);

  // Master side
  ahbPkg::ahbReqT      [Masters-1:0]             mstToSlv;
  logic                [Masters-1:0][Slaves-1:0] mstSelVec;
  matrixPkg::priorityT [Masters-1:0]             mstPri;
  logic                [Masters-1:0]             mstCanSwitch;
  logic                [Masters-1:0][Slaves-1:0] mstGranted;

  // Slave side
  ahbPkg::ahbReqT      [Slaves-1:0][Masters-1:0] slvIn;
  logic                [Slaves-1:0][Masters-1:0] slvSelIn;
  logic                [Slaves-1:0][Masters-1:0] slvGrant;
  ahbPkg::ahbRespT     [Slaves-1:0]              slvPortResp;

  function automatic ahbPkg::ahbReqT withSel(input ahbPkg::ahbReqT req, input logic sel);
    ahbPkg::ahbReqT r;
    r     = req;
    r.sel = sel;
    return r;
  endfunction

  ////////////////////////////////////////
  // Master ports
  ////////////////////////////////////////

  for (genvar m = 0; m < Masters; m++) begin : genMasterPort
    masterPort #(
      .Slaves   (Slaves),
      .SlaveBase(SlaveBase),
      .SlaveMask(SlaveMask)
    ) port (
      .HCLK       (HCLK),
      .reset      (reset),
      .mstReq     (masterReq[m]),
      .mstPriority(masterPriority[m]),
      .mstResp    (masterResp[m]),
      .slvResp    (slvPortResp),
      .granted    (mstGranted[m]),
      .slvReq     (mstToSlv[m]),
      .slvSel     (mstSelVec[m]),
      .slvPriority(mstPri[m]),
      .canSwitch  (mstCanSwitch[m])
    );
  end

  // Transpose, select bit s of each master goes to slave s
  for (genvar s = 0; s < Slaves; s++) begin : genCross
    for (genvar m = 0; m < Masters; m++) begin : genMaster
      assign slvIn[s][m]      = withSel(mstToSlv[m], mstSelVec[m][s]);
      assign slvSelIn[s][m]   = mstSelVec[m][s];
      assign mstGranted[m][s] = slvGrant[s][m];
    end
  end

  ////////////////////////////////////////
  // Slave ports
  ////////////////////////////////////////

  for (genvar s = 0; s < Slaves; s++) begin : genSlavePort
    slavePort #(
      .Masters(Masters)
    ) port (
      .HCLK       (HCLK),
      .reset      (reset),
      .mstReq     (slvIn[s]),
      .mstPriority(mstPri),
      .mstSel     (slvSelIn[s]),
      .canSwitch  (mstCanSwitch),
      .mstResp    (slvPortResp[s]),
      .grant      (slvGrant[s]),
      .slvReq     (slaveReq[s]),
      .slvResp    (slaveResp[s])
    );
  end

endmodule

/* src/ahbMemory.sv */
/*
 * AHB-Lite word memory slave
 * Fixed number of wait states per access
 */
`timescale 1ns/1ns

module ahbMemory #(
  parameter int MemWords   = 64,
  parameter int WaitStates = 1
) (
  input  logic            HCLK,
  input  logic            reset,
  input  ahbPkg::ahbReqT  req,
  output ahbPkg::ahbRespT resp
);

  localparam int IdxBits = $clog2(MemWords);
  localparam int CntBits = $clog2(WaitStates + 2);

  ahbPkg::dataT        mem [MemWords];
  logic                active;
  logic                writeReg;
  logic [IdxBits-1:0]  idxReg;
  logic [CntBits-1:0]  waitCnt;
  logic                accept;
  logic                lastCycle;

  // Address phase taken while the previous data phase ends
  assign accept    = req.sel && req.trans[1] && resp.readyOut;
  assign lastCycle = active && (waitCnt == '0);

  always_comb begin
    resp          = '0;
    resp.readyOut = !active || (waitCnt == '0);
    resp.resp     = ahbPkg::RespOkay;
    if (active) begin
      resp.rdata = mem[idxReg];
    end
  end

  always_ff @(posedge HCLK) begin
    if (reset) begin
      active  <= 1'b0;
      waitCnt <= '0;
    end else if (accept) begin
      active  <= 1'b1;
      waitCnt <= CntBits'(WaitStates);
    end else if (lastCycle) begin
      active <= 1'b0;
    end else if (active) begin
      waitCnt <= waitCnt - 1'b1;
    end
  end

  // Word index below the decode mask
  always_ff @(posedge HCLK) begin
    if (accept) begin
      writeReg <= req.write;
      idxReg   <= req.addr[2 +: IdxBits];
    end
    if (lastCycle && writeReg) begin
      mem[idxReg] <= req.wdata;
    end
  end

endmodule

/* src/subsystemTop.sv */
/*
 * Bus matrix subsystem
 * Matrix with two memory slaves on a fixed address map
 */
`timescale 1ns/1ns

module subsystemTop #(
  parameter int Masters    = 2,
  parameter int MemWords   = 64,
  parameter int WaitStates = 1
) (
  input  logic                              HCLK,
  input  logic                              reset,
  input  ahbPkg::ahbReqT      [Masters-1:0] masterReq,
  input  matrixPkg::priorityT [Masters-1:0] masterPriority,
  output ahbPkg::ahbRespT     [Masters-1:0] masterResp
);

  localparam int Slaves = 2;

  // Slave 1 at 0x1000_0000, slave 0 at 0x0000_0000
  localparam ahbPkg::addrT [Slaves-1:0] SlaveBase = {32'h1000_0000, 32'h0000_0000};
  localparam ahbPkg::addrT [Slaves-1:0] SlaveMask = {32'hF000_0000, 32'hF000_0000};

  ahbPkg::ahbReqT  [Slaves-1:0] slaveReq;
  ahbPkg::ahbRespT [Slaves-1:0] slaveResp;

  busMatrix #(
    .Masters  (Masters),
    .Slaves   (Slaves),
    .SlaveBase(SlaveBase),
    .SlaveMask(SlaveMask)
  ) matrix (
    .HCLK          (HCLK),
    .reset         (reset),
    .masterReq     (masterReq),
    .masterPriority(masterPriority),
    .masterResp    (masterResp),
    .slaveReq      (slaveReq),
    .slaveResp     (slaveResp)
  );

  for (genvar s = 0; s < Slaves; s++) begin : genMemory
    ahbMemory #(
      .MemWords  (MemWords),
      .WaitStates(WaitStates)
    ) memory (
      .HCLK (HCLK),
      .reset(reset),
      .req  (slaveReq[s]),
      .resp (slaveResp[s])
    );
  end

endmodule

/* verification/busMatrixAssert.sv */
/*
 * Bus matrix checks
 * Grant ownership, grant holding and the ERROR response shape
 */
`timescale 1ns/1ns

module busMatrixAssert #(
  parameter int Masters = 2,
  parameter int Slaves  = 2
) (
  input logic                              HCLK,
  input logic                              reset,
  input logic [Slaves-1:0][Masters-1:0]    slvGrant,
  input logic [Masters-1:0]                mstCanSwitch,
  input ahbPkg::ahbRespT [Masters-1:0]     masterResp
);

  // Number of failed assertions in the matrix
  int assertFails = 0;

  for (genvar s = 0; s < Slaves; s++) begin : genSlave
    // At most one owner per slave
    grantOneHot: assert property (@(posedge HCLK) disable iff (reset) $onehot0(slvGrant[s]))
      else begin
        assertFails++;
        $error("slave %0d grant %b is not one-hot", s, slvGrant[s]);
      end

    // Owner in a data phase or locked keeps the slave
    grantHold: assert property (@(posedge HCLK) disable iff (reset)
      |(slvGrant[s] & ~mstCanSwitch) |=> slvGrant[s] == $past(slvGrant[s]))
      else begin
        assertFails++;
        $error("slave %0d grant moved while the owner could not switch", s);
      end
  end

  for (genvar m = 0; m < Masters; m++) begin : genMaster
    // First ERROR cycle stalls the master
    errorFirst: assert property (@(posedge HCLK) disable iff (reset)
      $rose(masterResp[m].resp) |-> !masterResp[m].readyOut)
      else begin
        assertFails++;
        $error("master %0d ERROR response started with readyOut high", m);
      end
  end

endmodule

// Attach to the matrix, which sees every grant and every master response
bind busMatrix busMatrixAssert #(
  .Masters(Masters),
  .Slaves (Slaves)
) matrixChecks (
  .HCLK        (HCLK),
  .reset       (reset),
  .slvGrant    (slvGrant),
  .mstCanSwitch(mstCanSwitch),
  .masterResp  (masterResp)
);

/* verification/tbSubsystem.sv */
/*
 * Bus matrix subsystem testbench
 * Two master models, directed tests, memory scoreboard and watchdog
 */
`timescale 1ns/1ns

module tbSubsystem;

  localparam int Masters       = 2;
  localparam int MemWords      = 64;
  localparam int ClkPeriod     = 40;
  localparam int ResetCycles   = 5;
  localparam int NumTests      = 5;
  localparam int XfersPerTest  = 8;
  // 20 cycles per transfer is far above the worst contended latency
  localparam int TimeoutCycles = NumTests * XfersPerTest * 20 + ResetCycles;

  logic                              HCLK;
  logic                              reset;
  ahbPkg::ahbReqT      [Masters-1:0] masterReq;
  matrixPkg::priorityT [Masters-1:0] masterPriority;
  ahbPkg::ahbRespT     [Masters-1:0] masterResp;

  // Expected memory contents, one row per slave
  ahbPkg::dataT sbMem [2][MemWords];
  time          doneTime [Masters];
  int           seed;
  int           errorCount;
  int           checkCount;
  int           testCount;

  subsystemTop #(
    .Masters   (Masters),
    .MemWords  (MemWords),
    .WaitStates(1)
  ) uut (
    .HCLK          (HCLK),
    .reset         (reset),
    .masterReq     (masterReq),
    .masterPriority(masterPriority),
    .masterResp    (masterResp)
  );

  initial begin
    HCLK = 1'b0;
  end

  always #(ClkPeriod / 2) HCLK = ~HCLK;

  ////////////////////////////////////////
  // Checks and master model
  ////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic endTest(input string name, input int startErrors);
    testCount++;
    $display("Test %0d %s finished with %0d errors", testCount, name, errorCount - startErrors);
  endtask

  // Word aligned addresses with slave 0 at 0x0000_0000 and slave 1 at 0x1000_0000
  function automatic ahbPkg::addrT wordAddr(input int s, input int word);
    return ((s == 1) ? 32'h1000_0000 : 32'h0000_0000) + 32'(word * 4);
  endfunction

  // Starts on a falling edge and returns on the falling edge after completion
  task automatic busTransfer(input int m, input ahbPkg::addrT addr, input logic write,
                             input ahbPkg::dataT wdata, input logic lock,
                             output ahbPkg::dataT rdata, output logic resp);
    masterReq[m].sel      = 1'b1;
    masterReq[m].addr     = addr;
    masterReq[m].write    = write;
    masterReq[m].size     = 3'b010;
    masterReq[m].trans    = ahbPkg::NONSEQ;
    masterReq[m].mastLock = lock;
    masterReq[m].wdata    = wdata;
    // Address phase is taken on the next rising edge with ready high
    while (!masterResp[m].readyOut) begin
      @(negedge HCLK);
    end
    @(negedge HCLK);
    masterReq[m].sel   = 1'b0;
    masterReq[m].trans = ahbPkg::IDLE;
    // Data phase with write data held until ready
    while (!masterResp[m].readyOut) begin
      @(negedge HCLK);
    end
    rdata       = masterResp[m].rdata;
    resp        = masterResp[m].resp;
    doneTime[m] = $time;
    @(negedge HCLK);
  endtask

  task automatic writeWord(input int m, input int s, input int word);
    ahbPkg::dataT data;
    ahbPkg::dataT rdata;
    logic         resp;
    data = $random(seed);
    busTransfer(m, wordAddr(s, word), 1'b1, data, 1'b0, rdata, resp);
    checkValue("masterResp.resp", 32'(resp), 32'h0);
    sbMem[s][word] = data;
  endtask

  task automatic readWord(input int m, input int s, input int word);
    ahbPkg::dataT rdata;
    logic         resp;
    busTransfer(m, wordAddr(s, word), 1'b0, '0, 1'b0, rdata, resp);
    checkValue("masterResp.resp", 32'(resp), 32'h0);
    checkValue("masterResp.rdata", rdata, sbMem[s][word]);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic testWriteRead();
    int startErrors;
    startErrors = errorCount;
    for (int m = 0; m < Masters; m++) begin
      for (int s = 0; s < 2; s++) begin
        writeWord(m, s, m);
        readWord(m, s, m);
      end
    end
    endTest("write then read", startErrors);
  endtask

  task automatic testUnmapped();
    int           startErrors;
    ahbPkg::dataT data;
    ahbPkg::dataT rdata;
    logic         resp;
    startErrors = errorCount;
    data = $random(seed);
    busTransfer(0, 32'h2000_0000, 1'b1, data, 1'b0, rdata, resp);
    checkValue("masterResp.resp", 32'(resp), 32'h1);
    busTransfer(1, 32'h2000_0004, 1'b0, '0, 1'b0, rdata, resp);
    checkValue("masterResp.resp", 32'(resp), 32'h1);
    // Word 0 of both memories must still hold the earlier data
    readWord(0, 0, 0);
    readWord(0, 1, 0);
    endTest("unmapped address", startErrors);
  endtask

  task automatic testContention();
    int startErrors;
    startErrors = errorCount;
    masterPriority[0] = 3'd2;
    masterPriority[1] = 3'd5;
    fork
      writeWord(0, 0, 8);
      writeWord(1, 0, 9);
    join
    // Master 1 has the higher priority
    checkValue("master 1 done first", 32'(doneTime[1] < doneTime[0]), 32'h1);
    fork
      readWord(0, 0, 8);
      readWord(1, 0, 9);
    join
    endTest("contention", startErrors);
  endtask

  task automatic testParallel();
    int startErrors;
    startErrors = errorCount;
    fork
      writeWord(0, 0, 16);
      writeWord(1, 1, 16);
    join
    fork
      readWord(0, 0, 16);
      readWord(1, 1, 16);
    join
    endTest("parallel slaves", startErrors);
  endtask

  task automatic testLocked();
    int           startErrors;
    ahbPkg::dataT data [3];
    ahbPkg::dataT rdata;
    logic         resp;
    time          lockDone;
    time          otherDone;
    startErrors = errorCount;
    // Master 0 outranks master 1 but the lock must still win
    masterPriority[0] = 3'd6;
    masterPriority[1] = 3'd1;
    for (int i = 0; i < 3; i++) begin
      data[i] = $random(seed);
    end
    fork
      begin
        busTransfer(1, wordAddr(0, 24), 1'b1, data[0], 1'b1, rdata, resp);
        busTransfer(1, wordAddr(0, 25), 1'b1, data[1], 1'b1, rdata, resp);
        lockDone = doneTime[1];
        masterReq[1].mastLock = 1'b0;
      end
      begin
        @(negedge HCLK);
        busTransfer(0, wordAddr(0, 26), 1'b1, data[2], 1'b0, rdata, resp);
        otherDone = doneTime[0];
      end
    join
    checkValue("master 0 after lock", 32'(otherDone > lockDone), 32'h1);
    for (int i = 0; i < 3; i++) begin
      sbMem[0][24 + i] = data[i];
      readWord(0, 0, 24 + i);
    end
    endTest("locked sequence", startErrors);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    int assertFails;
    seed           = 32'hdbe4_1b3a;
    errorCount     = 0;
    checkCount     = 0;
    testCount      = 0;
    reset          = 1'b1;
    masterReq      = '0;
    masterPriority = '0;
    repeat (ResetCycles) @(posedge HCLK);
    @(negedge HCLK);
    reset = 1'b0;
    // Idle response after reset
    for (int m = 0; m < Masters; m++) begin
      checkValue("masterResp.readyOut", 32'(masterResp[m].readyOut), 32'h1);
      checkValue("masterResp.resp", 32'(masterResp[m].resp), 32'h0);
    end
    testWriteRead();
    testUnmapped();
    testContention();
    testParallel();
    testLocked();
    assertFails = uut.matrix.matrixChecks.assertFails;
    if (assertFails != 0) begin
      $display("Bus matrix assertions failed %0d times", assertFails);
      errorCount += assertFails;
    end
    $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Watchdog expired, the tests did not finish in %0d cycles", TimeoutCycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* verilog.f */
common/ahbPkg.sv
common/matrixPkg.sv
busMatrix/masterPort.sv
busMatrix/slavePort.sv
busMatrix/busMatrix.sv
src/ahbMemory.sv
src/subsystemTop.sv
verification/busMatrixAssert.sv
verification/tbSubsystem.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tbSubsystem -f verilog.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -qxF '>>> PASS' &&
echo "Simulation succeeded" ||
{ echo "Simulation did not succeed"; exit 1; }
